// File: rtl/vec_control.sv
// vector instruction sequencer
// holds vl and SEW, runs config, memory and arithmetic instructions
// and answers the CPU over PCPI
`timescale 1ns/1ps
`default_nettype none

module vec_control import vec_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     pcpi_valid,
	input  xword_t   pcpi_rs2,
	input  vec_cmd_t cmd,
	output logic     pcpi_wr,
	output logic     pcpi_wait,
	output logic     pcpi_ready,
	output xword_t   pcpi_rd,
	output logic     mem_start,
	output logic     mem_store,
	output xword_t   mem_base,
	output wcount_t  mem_count,
	input  logic     mem_done,
	output logic     alu_start,
	output vec_op_e  alu_op,
	output sew_e     sew,
	input  logic     alu_done,
	output vidx_t    rd_idx1,
	output vidx_t    rd_idx2,
	output vidx_t    rd_idx3,
	output vidx_t    wr_idx,
	output logic     vec_we
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CFG,
		ST_MEM,
		ST_EXEC,
		ST_WRITE,
		ST_DONE
	} state_e;

	state_e     state;
	vl_t        vl;
	logic       ready_q;
	vidx_t      vd_q;
	vidx_t      vs1_q;
	vidx_t      vs2_q;
	logic [2:0] vsew_raw;
	sew_e       cfg_sew;
	vl_t        cfg_vlmax;
	xword_t     avl;
	vl_t        cfg_vl;
	wcount_t    words;

	// new vtype and vl, valid while in ST_CFG
	always_comb begin
		vsew_raw = cmd.vsetvl ? pcpi_rs2[4:2] : cmd.vsew;
		cfg_sew  = (vsew_raw > 3'd2) ? SEW32 : sew_e'(vsew_raw[1:0]);
		case (cfg_sew)
			SEW8:    cfg_vlmax = 7'd64;
			SEW16:   cfg_vlmax = 7'd32;
			default: cfg_vlmax = 7'd16;
		endcase
		// rs1 = x0 keeps the current vl
		avl    = cmd.rs1_nz ? cmd.rs1_val : xword_t'(vl);
		cfg_vl = (avl > xword_t'(cfg_vlmax)) ? cfg_vlmax : vl_t'(avl);
	end

	// words moved by a load or store, vl * SEW / 32 rounded up
	always_comb begin
		case (sew)
			SEW8:    words = wcount_t'((vl + 7'd3) >> 2);
			SEW16:   words = wcount_t'((vl + 7'd1) >> 1);
			default: words = wcount_t'(vl);
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_IDLE;
			vl        <= '0;
			sew       <= SEW8;
			ready_q   <= 1'b0;
			mem_start <= 1'b0;
			alu_start <= 1'b0;
		end else begin
			ready_q   <= 1'b0;
			mem_start <= 1'b0;
			alu_start <= 1'b0;
			case (state)
				ST_IDLE: begin
					case (cmd.op)
						OP_CFG: state <= ST_CFG;
						OP_LOAD, OP_STORE: begin
							if (words == '0) begin
								ready_q <= 1'b1;
								state   <= ST_DONE;
							end else begin
								mem_start <= 1'b1;
								state     <= ST_MEM;
							end
						end
						OP_ADD, OP_MACC: begin
							alu_start <= 1'b1;
							state     <= ST_EXEC;
						end
						default: state <= ST_IDLE;
					endcase
				end
				ST_CFG: begin
					vl    <= cfg_vl;
					sew   <= cfg_sew;
					state <= ST_DONE;
				end
				ST_MEM: begin
					if (mem_done) begin
						ready_q <= 1'b1;
						state   <= ST_DONE;
					end
				end
				ST_EXEC: begin
					if (alu_done)
						state <= ST_WRITE;
				end
				ST_WRITE: begin
					ready_q <= 1'b1;
					state   <= ST_DONE;
				end
				// hold until the CPU withdraws the instruction
				ST_DONE: begin
					if (!pcpi_valid)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// operands captured once, as the instruction starts
	always_ff @(posedge clk) begin
		if (state == ST_IDLE) begin
			vd_q      <= cmd.vd;
			vs1_q     <= cmd.vs1;
			vs2_q     <= cmd.vs2;
			mem_base  <= cmd.rs1_val;
			mem_count <= words;
			mem_store <= (cmd.op == OP_STORE);
			alu_op    <= cmd.op;
		end
	end

	assign rd_idx1 = vs1_q;
	assign rd_idx2 = vs2_q;
	assign rd_idx3 = vd_q;
	assign wr_idx  = vd_q;
	assign vec_we  = (state == ST_WRITE);

	// config answers straight from ST_CFG, the rest through ready_q
	assign pcpi_wr    = (state == ST_CFG);
	assign pcpi_rd    = xword_t'(cfg_vl);
	assign pcpi_ready = ready_q || (state == ST_CFG);
	assign pcpi_wait  = (state != ST_IDLE) && (state != ST_DONE);

endmodule

`default_nettype wire

// File: rtl/vec_copro_top.sv
// vector coprocessor top level
// joins the PCPI and memory ports to the decoder, sequencer and datapath
`timescale 1ns/1ps
`default_nettype none

module vec_copro_top import vec_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       pcpi_valid,
	input  xword_t     pcpi_insn,
	input  xword_t     pcpi_rs1,
	input  xword_t     pcpi_rs2,
	output logic       pcpi_wr,
	output xword_t     pcpi_rd,
	output logic       pcpi_wait,
	output logic       pcpi_ready,
	input  logic       mem_ready,
	input  xword_t     mem_rdata,
	output logic       mem_valid,
	output xword_t     mem_addr,
	output xword_t     mem_wdata,
	output logic [3:0] mem_wstrb
);

	vec_cmd_t cmd;
	logic     mem_start;
	logic     mem_store;
	xword_t   mem_base;
	wcount_t  mem_count;
	logic     mem_done;
	logic     word_we;
	widx_t    word_idx;
	xword_t   word_data;
	logic     alu_start;
	vec_op_e  alu_op;
	sew_e     sew;
	logic     alu_done;
	vreg_t    alu_result;
	vidx_t    rd_idx1;
	vidx_t    rd_idx2;
	vidx_t    rd_idx3;
	vidx_t    wr_idx;
	logic     vec_we;
	vreg_t    rd_data1;
	vreg_t    rd_data2;
	vreg_t    rd_data3;

	vec_decoder u_decoder (
		.clk(clk), .reset(reset), .pcpi_valid(pcpi_valid),
		.pcpi_insn(pcpi_insn), .pcpi_rs1(pcpi_rs1), .cmd(cmd)
	);

	vec_control u_control (
		.clk(clk), .reset(reset), .pcpi_valid(pcpi_valid), .pcpi_rs2(pcpi_rs2),
		.cmd(cmd), .pcpi_wr(pcpi_wr), .pcpi_wait(pcpi_wait), .pcpi_ready(pcpi_ready),
		.pcpi_rd(pcpi_rd), .mem_start(mem_start), .mem_store(mem_store),
		.mem_base(mem_base), .mem_count(mem_count), .mem_done(mem_done),
		.alu_start(alu_start), .alu_op(alu_op), .sew(sew), .alu_done(alu_done),
		.rd_idx1(rd_idx1), .rd_idx2(rd_idx2), .rd_idx3(rd_idx3),
		.wr_idx(wr_idx), .vec_we(vec_we)
	);

	// store data is read through the vd port
	vec_mem_port u_mem_port (
		.clk(clk), .reset(reset), .mem_start(mem_start), .mem_store(mem_store),
		.mem_base(mem_base), .mem_count(mem_count), .store_vec(rd_data3),
		.mem_ready(mem_ready), .mem_rdata(mem_rdata), .mem_valid(mem_valid),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
		.mem_done(mem_done), .word_we(word_we), .word_idx(word_idx), .word_data(word_data)
	);

	vec_lane_alu u_lane_alu (
		.clk(clk), .reset(reset), .alu_start(alu_start), .alu_op(alu_op), .sew(sew),
		.src1(rd_data1), .src2(rd_data2), .src3(rd_data3),
		.alu_done(alu_done), .result(alu_result)
	);

	vec_regfile u_regfile (
		.clk(clk), .rd_idx1(rd_idx1), .rd_idx2(rd_idx2), .rd_idx3(rd_idx3),
		.rd_data1(rd_data1), .rd_data2(rd_data2), .rd_data3(rd_data3),
		.vec_we(vec_we), .wr_idx(wr_idx), .wr_data(alu_result),
		.word_we(word_we), .word_idx(word_idx), .word_data(word_data)
	);

endmodule

`default_nettype wire

// File: rtl/vec_decoder.sv
// vector instruction decoder
// classifies the offered PCPI instruction and registers its fields
`timescale 1ns/1ps
`default_nettype none

module vec_decoder import vec_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      pcpi_valid,
	input  vec_insn_u pcpi_insn,
	input  xword_t    pcpi_rs1,
	output vec_cmd_t  cmd
);

	vec_op_e op_d;
	logic    unit_stride;

	// only plain unit-stride, single field transfers
	assign unit_stride = (pcpi_insn.mem.nf == 3'd0) && !pcpi_insn.mem.mew &&
		(pcpi_insn.mem.mop == 2'd0) && (pcpi_insn.mem.lumop == 5'd0);

	always_comb begin
		op_d = OP_NONE;
		case (pcpi_insn.arith.opcode)
			OPC_OP_V: begin
				// vsetvl needs bits 30:25 clear
				if (pcpi_insn.cfg.funct3 == F3_OPCFG) begin
					if (!pcpi_insn.cfg.form || (pcpi_insn.cfg.zimm[10:5] == 6'd0))
						op_d = OP_CFG;
				end else if (pcpi_insn.arith.funct3 == F3_OPIVV) begin
					if (pcpi_insn.arith.funct6 == F6_VADD)
						op_d = OP_ADD;
					else if (pcpi_insn.arith.funct6 == F6_VMACC)
						op_d = OP_MACC;
				end
			end
			OPC_LOAD_FP:  op_d = unit_stride ? OP_LOAD : OP_NONE;
			OPC_STORE_FP: op_d = unit_stride ? OP_STORE : OP_NONE;
			default:      op_d = OP_NONE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd.op <= OP_NONE;
		end else begin
			cmd.op      <= pcpi_valid ? op_d : OP_NONE;
			cmd.vd      <= pcpi_insn.arith.vd;
			cmd.vs1     <= pcpi_insn.arith.vs1;
			cmd.vs2     <= pcpi_insn.arith.vs2;
			cmd.rs1_nz  <= (pcpi_insn.cfg.rs1 != 5'd0);
			cmd.vsetvl  <= pcpi_insn.cfg.form;
			cmd.vsew    <= pcpi_insn.cfg.zimm[4:2];
			cmd.rs1_val <= pcpi_rs1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/vec_lane_alu.sv
// word-serial SIMD add and multiply-accumulate
// one 32-bit word per cycle, split into 8, 16 or 32-bit lanes
`timescale 1ns/1ps
`default_nettype none

module vec_lane_alu import vec_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    alu_start,
	input  vec_op_e alu_op,
	input  sew_e    sew,
	input  vreg_t   src1,
	input  vreg_t   src2,
	input  vreg_t   src3,
	output logic    alu_done,
	output vreg_t   result
);

	logic   run;
	widx_t  cnt;
	logic   issue;
	logic   lane_vld;
	widx_t  lane_idx;
	xword_t lane_q;
	xword_t a;
	xword_t b;
	xword_t c;
	xword_t lane_d;
	logic   macc;

	assign issue = alu_start || run;
	assign macc  = (alu_op == OP_MACC);

	// vd = vs1 * vs2 + vd or vd = vs1 + vs2, wrapping per lane
	always_comb begin
		a = src1[cnt*XLEN +: XLEN];
		b = src2[cnt*XLEN +: XLEN];
		c = src3[cnt*XLEN +: XLEN];
		case (sew)
			SEW8:
				for (int i = 0; i < 4; i++)
					lane_d[8*i +: 8] = macc ? a[8*i +: 8] * b[8*i +: 8] + c[8*i +: 8]
						: a[8*i +: 8] + b[8*i +: 8];
			SEW16:
				for (int i = 0; i < 2; i++)
					lane_d[16*i +: 16] = macc ? a[16*i +: 16] * b[16*i +: 16] + c[16*i +: 16]
						: a[16*i +: 16] + b[16*i +: 16];
			default:
				lane_d = macc ? a * b + c : a + b;
		endcase
	end

	// cnt wraps back to zero after the last word
	always_ff @(posedge clk) begin
		if (reset) begin
			run      <= 1'b0;
			cnt      <= '0;
			lane_vld <= 1'b0;
			alu_done <= 1'b0;
		end else begin
			lane_vld <= issue;
			alu_done <= lane_vld && (lane_idx == widx_t'(VWORDS-1));
			if (issue) begin
				cnt <= cnt + widx_t'(1);
				run <= (cnt != widx_t'(VWORDS-1));
			end
		end
	end

	always_ff @(posedge clk) begin
		lane_q   <= lane_d;
		lane_idx <= cnt;
		if (lane_vld)
			result[lane_idx*XLEN +: XLEN] <= lane_q;
	end

endmodule

`default_nettype wire

// File: rtl/vec_mem_port.sv
// word-serial memory engine for unit-stride vector loads and stores
`timescale 1ns/1ps
`default_nettype none

module vec_mem_port import vec_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       mem_start,
	input  logic       mem_store,
	input  xword_t     mem_base,
	input  wcount_t    mem_count,
	input  vreg_t      store_vec,
	input  logic       mem_ready,
	input  xword_t     mem_rdata,
	output logic       mem_valid,
	output xword_t     mem_addr,
	output xword_t     mem_wdata,
	output logic [3:0] mem_wstrb,
	output logic       mem_done,
	output logic       word_we,
	output widx_t      word_idx,
	output xword_t     word_data
);

	logic    active;
	logic    store_q;
	vreg_t   vec_q;
	widx_t   idx;
	wcount_t left;
	logic    xfer;

	assign xfer = mem_valid && mem_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			active    <= 1'b0;
			mem_valid <= 1'b0;
			mem_done  <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			if (mem_start) begin
				active    <= 1'b1;
				mem_valid <= 1'b1;
			end else if (xfer) begin
				// drop valid for a cycle between words
				mem_valid <= 1'b0;
				if (left == wcount_t'(1)) begin
					active   <= 1'b0;
					mem_done <= 1'b1;
				end
			end else if (active && !mem_valid) begin
				mem_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem_start) begin
			mem_addr <= mem_base;
			left     <= mem_count;
			idx      <= '0;
			store_q  <= mem_store;
			vec_q    <= store_vec;
		end else if (xfer) begin
			mem_addr <= mem_addr + xword_t'(4);
			left     <= left - wcount_t'(1);
			idx      <= idx + widx_t'(1);
		end
	end

	assign mem_wdata = vec_q[idx*XLEN +: XLEN];
	assign mem_wstrb = store_q ? 4'hf : 4'h0;

	// returned load word goes straight into the register file
	assign word_we   = xfer && !store_q;
	assign word_idx  = idx;
	assign word_data = mem_rdata;

endmodule

`default_nettype wire

// File: rtl/vec_pkg.sv
// vector coprocessor shared definitions
// sizes, instruction encodings, instruction views and the decoded command
`default_nettype none

package vec_pkg;

	localparam int XLEN   = 32;
	localparam int VLEN   = 512;
	localparam int VWORDS = VLEN / XLEN;
	localparam int NVREG  = 32;

	typedef logic [XLEN-1:0] xword_t;
	typedef logic [VLEN-1:0] vreg_t;
	typedef logic [4:0]      vidx_t;
	typedef logic [3:0]      widx_t;
	typedef logic [4:0]      wcount_t;
	typedef logic [6:0]      vl_t;

	// same code points as the vtype vsew field
	typedef enum logic [1:0] {
		SEW8  = 2'd0,
		SEW16 = 2'd1,
		SEW32 = 2'd2
	} sew_e;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_CFG,
		OP_LOAD,
		OP_STORE,
		OP_ADD,
		OP_MACC
	} vec_op_e;

	localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
	localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
	localparam logic [6:0] OPC_OP_V     = 7'b1010111;
	localparam logic [2:0] F3_OPCFG     = 3'b111;
	localparam logic [2:0] F3_OPIVV     = 3'b000;
	localparam logic [5:0] F6_VADD      = 6'b000000;
	localparam logic [5:0] F6_VMACC     = 6'b111001;

	typedef struct packed {
		logic [5:0] funct6;
		logic       vm;
		vidx_t      vs2;
		vidx_t      vs1;
		logic [2:0] funct3;
		vidx_t      vd;
		logic [6:0] opcode;
	} insn_arith_t;

	// form bit set selects vsetvl
	typedef struct packed {
		logic        form;
		logic [10:0] zimm;
		vidx_t       rs1;
		logic [2:0]  funct3;
		vidx_t       rd;
		logic [6:0]  opcode;
	} insn_cfg_t;

	typedef struct packed {
		logic [2:0] nf;
		logic       mew;
		logic [1:0] mop;
		logic       vm;
		logic [4:0] lumop;
		vidx_t      rs1;
		logic [2:0] width;
		vidx_t      vd;
		logic [6:0] opcode;
	} insn_mem_t;

	typedef union packed {
		insn_arith_t arith;
		insn_cfg_t   cfg;
		insn_mem_t   mem;
	} vec_insn_u;

	typedef struct packed {
		vec_op_e    op;
		vidx_t      vd;
		vidx_t      vs1;
		vidx_t      vs2;
		logic       rs1_nz;
		logic       vsetvl;
		logic [2:0] vsew;
		xword_t     rs1_val;
	} vec_cmd_t;

endpackage

`default_nettype wire

// File: rtl/vec_regfile.sv
// vector register file, 32 x 512 bits
// three combinational reads, whole-register write and single-word write
`timescale 1ns/1ps
`default_nettype none

module vec_regfile import vec_pkg::*; (
	input  logic   clk,
	input  vidx_t  rd_idx1,
	input  vidx_t  rd_idx2,
	input  vidx_t  rd_idx3,
	output vreg_t  rd_data1,
	output vreg_t  rd_data2,
	output vreg_t  rd_data3,
	input  logic   vec_we,
	input  vidx_t  wr_idx,
	input  vreg_t  wr_data,
	input  logic   word_we,
	input  widx_t  word_idx,
	input  xword_t word_data
);

	vreg_t regs [NVREG];

	assign rd_data1 = regs[rd_idx1];
	assign rd_data2 = regs[rd_idx2];
	assign rd_data3 = regs[rd_idx3];

	// word writes come from loads and leave the other words alone
	always_ff @(posedge clk) begin
		if (vec_we)
			regs[wr_idx] <= wr_data;
		else if (word_we)
			regs[wr_idx][word_idx*XLEN +: XLEN] <= word_data;
	end

endmodule

`default_nettype wire

// File: sim/tb_vec_copro.sv
// testbench for the vector coprocessor
// drives PCPI instructions against a 256-word memory model with random
// ready delays and compares stored results with a lane reference model
`timescale 1ns/1ps
`default_nettype none

module tb_vec_copro import vec_pkg::*; ();

	// about ten times the longest instruction sequence
	localparam int TIMEOUT_CYCLES = 20000;

	logic       clk;
	logic       reset      = 1'b1;
	logic       pcpi_valid = 1'b0;
	xword_t     pcpi_insn  = '0;
	xword_t     pcpi_rs1   = '0;
	xword_t     pcpi_rs2   = '0;
	logic       pcpi_wr;
	xword_t     pcpi_rd;
	logic       pcpi_wait;
	logic       pcpi_ready;
	logic       mem_ready  = 1'b0;
	xword_t     mem_rdata  = '0;
	logic       mem_valid;
	xword_t     mem_addr;
	xword_t     mem_wdata;
	logic [3:0] mem_wstrb;

	xword_t mem [256];
	integer seed        = 41029;
	int     store_words = 0;
	logic   pending     = 1'b0;
	int     wait_left   = 0;
	int     cycle_count = 0;
	int     check_count = 0;
	int     error_count = 0;
	int     test_checks;
	int     test_errors;
	string  test_name;

	vec_copro_top i_dut (
		.clk(clk), .reset(reset), .pcpi_valid(pcpi_valid), .pcpi_insn(pcpi_insn),
		.pcpi_rs1(pcpi_rs1), .pcpi_rs2(pcpi_rs2), .pcpi_wr(pcpi_wr), .pcpi_rd(pcpi_rd),
		.pcpi_wait(pcpi_wait), .pcpi_ready(pcpi_ready), .mem_ready(mem_ready),
		.mem_rdata(mem_rdata), .mem_valid(mem_valid), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// memory model giving one ready pulse per request after 0 to 3 wait cycles
	always @(posedge clk) begin : memory_model
		int d;
		mem_ready <= 1'b0;
		if (reset) begin
			pending <= 1'b0;
		end else if (mem_valid && !mem_ready) begin
			d = pending ? wait_left : ($random(seed) & 3);
			if (d == 0) begin
				mem_ready <= 1'b1;
				pending   <= 1'b0;
				if (mem_wstrb == 4'hf) begin
					mem[mem_addr[9:2]] <= mem_wdata;
					store_words        <= store_words + 1;
				end else begin
					mem_rdata <= mem[mem_addr[9:2]];
				end
			end else begin
				pending   <= 1'b1;
				wait_left <= d - 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$finish;
		end
	end

	// expected element-wise vs1 + vs2 or vs1 * vs2 + vd wrapped per element
	function automatic vreg_t lane_reference(input vreg_t a, input vreg_t b, input vreg_t c,
		input logic macc, input int width);
		vreg_t mask;
		vreg_t ea;
		vreg_t eb;
		vreg_t ec;
		vreg_t r;
		vreg_t res;
		res  = '0;
		mask = (vreg_t'(1) << width) - vreg_t'(1);
		for (int e = 0; e < VLEN / width; e++) begin
			ea  = (a >> (e * width)) & mask;
			eb  = (b >> (e * width)) & mask;
			ec  = (c >> (e * width)) & mask;
			r   = macc ? ea * eb + ec : ea + eb;
			res = res | ((r & mask) << (e * width));
		end
		return res;
	endfunction

	function automatic xword_t cfg_insn(input logic form, input vidx_t rs1f,
		input logic [2:0] vsew);
		// vsetvl names rs2 = x2 and vsetvli carries vsew in zimm[4:2]
		return {form, form ? {6'd0, 5'd2} : {6'd0, vsew, 2'b00}, rs1f, F3_OPCFG, 5'd1,
			OPC_OP_V};
	endfunction

	function automatic xword_t mem_insn(input logic store, input vidx_t vreg);
		return {3'b000, 1'b0, 2'b00, 1'b1, 5'd0, 5'd10, 3'b110, vreg,
			store ? OPC_STORE_FP : OPC_LOAD_FP};
	endfunction

	function automatic xword_t arith_insn(input logic macc, input vidx_t vd, input vidx_t vs1,
		input vidx_t vs2);
		return {macc ? F6_VMACC : F6_VADD, 1'b1, vs2, vs1, F3_OPIVV, vd, OPC_OP_V};
	endfunction

	task automatic check_value(input string what, input xword_t expected, input xword_t actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = check_count;
		test_errors = error_count;
	endtask

	task automatic report_test();
		$display("test %-10s %0d checks, %0d errors", test_name, check_count - test_checks,
			error_count - test_errors);
	endtask

	// offer one instruction and hold it until ready while sampling on the falling edge
	task automatic issue_insn(input xword_t insn, input xword_t rs1_val, input xword_t rs2_val,
		output xword_t rd_val, output logic wr_seen, output int latency);
		logic wait_seen;
		latency   = 0;
		wait_seen = 1'b0;
		@(posedge clk);
		pcpi_valid <= 1'b1;
		pcpi_insn  <= insn;
		pcpi_rs1   <= rs1_val;
		pcpi_rs2   <= rs2_val;
		@(negedge clk);
		while (!pcpi_ready) begin
			wait_seen = wait_seen | pcpi_wait;
			latency++;
			@(negedge clk);
		end
		// a config answer raises wait only in its ready cycle
		wait_seen = wait_seen | pcpi_wait;
		rd_val    = pcpi_rd;
		wr_seen   = pcpi_wr;
		check_value("pcpi_wait seen", 32'd1, xword_t'(wait_seen));
		@(posedge clk);
		pcpi_valid <= 1'b0;
	endtask

	task automatic set_config(input xword_t avl, input sew_e s, input xword_t expect_vl);
		xword_t rd;
		logic   wr;
		int     lat;
		issue_insn(cfg_insn(1'b0, 5'd10, {1'b0, s}), avl, '0, rd, wr, lat);
		check_value($sformatf("vl for avl %0d", avl), expect_vl, rd);
		check_value("cfg result write", 32'd1, xword_t'(wr));
		check_value("cfg latency", 32'd2, xword_t'(lat));
	endtask

	task automatic move_vector(input logic store, input vidx_t vreg, input xword_t addr);
		xword_t rd;
		logic   wr;
		int     lat;
		issue_insn(mem_insn(store, vreg), addr, '0, rd, wr, lat);
		check_value(store ? "store result write" : "load result write", '0, xword_t'(wr));
	endtask

	// sources at words 0 and 16 with the accumulator at 32 and the result at 48
	task automatic run_arith(input logic macc, input sew_e s);
		vreg_t  va;
		vreg_t  vb;
		vreg_t  vc;
		vreg_t  expected;
		xword_t rd;
		logic   wr;
		int     lat;
		vidx_t  dst;
		dst = macc ? 5'd5 : 5'd4;
		for (int i = 0; i < VWORDS; i++) begin
			va[i*XLEN +: XLEN] = $random(seed);
			vb[i*XLEN +: XLEN] = $random(seed);
			vc[i*XLEN +: XLEN] = $random(seed);
		end
		// word 0 overflows in every lane
		va[XLEN-1:0] = 32'hffffffff;
		vb[XLEN-1:0] = 32'h01010101;
		for (int i = 0; i < VWORDS; i++) begin
			mem[i]      = va[i*XLEN +: XLEN];
			mem[16 + i] = vb[i*XLEN +: XLEN];
			mem[32 + i] = vc[i*XLEN +: XLEN];
		end
		set_config(16, SEW32, 16);
		move_vector(1'b0, 5'd2, 32'h000);
		move_vector(1'b0, 5'd3, 32'h040);
		if (macc)
			move_vector(1'b0, dst, 32'h080);
		set_config(64, s, xword_t'(512 / (8 << int'(s))));
		issue_insn(arith_insn(macc, dst, 5'd2, 5'd3), '0, '0, rd, wr, lat);
		check_value("arith result write", '0, xword_t'(wr));
		set_config(16, SEW32, 16);
		move_vector(1'b1, dst, 32'h0c0);
		expected = lane_reference(va, vb, vc, macc, 8 << int'(s));
		for (int i = 0; i < VWORDS; i++)
			check_value($sformatf("sew%0d word %0d", 8 << int'(s), i),
				expected[i*XLEN +: XLEN], mem[48 + i]);
	endtask

	initial begin : main
		xword_t old_words [VWORDS];
		xword_t new_words [3];
		xword_t rd;
		logic   wr;
		int     lat;
		for (int i = 0; i < 256; i++)
			mem[i] = 32'hfeed0000 ^ (i * 32'h00010003);
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		start_test("reset");
		check_value("pcpi_ready", '0, xword_t'(pcpi_ready));
		check_value("pcpi_wait", '0, xword_t'(pcpi_wait));
		check_value("pcpi_wr", '0, xword_t'(pcpi_wr));
		check_value("mem_valid", '0, xword_t'(mem_valid));
		report_test();

		start_test("config");
		set_config(10, SEW16, 10);
		set_config(100, SEW8, 64);
		// vsetvl with rs1 = x0 keeps vl clamped to the SEW32 maximum
		issue_insn(cfg_insn(1'b1, 5'd0, 3'd0), '0, 32'd8, rd, wr, lat);
		check_value("vsetvl vl", 32'd16, rd);
		check_value("vsetvl result write", 32'd1, xword_t'(wr));
		report_test();

		start_test("load_store");
		set_config(16, SEW32, 16);
		for (int i = 0; i < VWORDS; i++) begin
			old_words[i] = $random(seed);
			mem[i]       = old_words[i];
		end
		move_vector(1'b0, 5'd1, 32'h000);
		store_words = 0;
		move_vector(1'b1, 5'd1, 32'h100);
		check_value("store count vl16", 32'd16, xword_t'(store_words));
		for (int i = 0; i < VWORDS; i++)
			check_value($sformatf("copy word %0d", i), old_words[i], mem[64 + i]);
		// vl 6 at SEW16 moves 3 words
		set_config(6, SEW16, 6);
		for (int i = 0; i < 3; i++) begin
			new_words[i] = $random(seed);
			mem[16 + i]  = new_words[i];
		end
		move_vector(1'b0, 5'd1, 32'h040);
		store_words = 0;
		move_vector(1'b1, 5'd1, 32'h280);
		check_value("store count vl6", 32'd3, xword_t'(store_words));
		set_config(16, SEW32, 16);
		store_words = 0;
		move_vector(1'b1, 5'd1, 32'h200);
		check_value("store count full", 32'd16, xword_t'(store_words));
		for (int i = 0; i < VWORDS; i++)
			check_value($sformatf("partial word %0d", i),
				(i < 3) ? new_words[i] : old_words[i], mem[128 + i]);
		report_test();

		start_test("vadd");
		run_arith(1'b0, SEW8);
		run_arith(1'b0, SEW16);
		run_arith(1'b0, SEW32);
		report_test();

		start_test("vmacc");
		run_arith(1'b1, SEW8);
		run_arith(1'b1, SEW16);
		run_arith(1'b1, SEW32);
		report_test();

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vec_copro.f
rtl/vec_pkg.sv
rtl/vec_decoder.sv
rtl/vec_control.sv
rtl/vec_regfile.sv
rtl/vec_mem_port.sv
rtl/vec_lane_alu.sv
rtl/vec_copro_top.sv
sim/tb_vec_copro.sv
